// ==== hw/conv_in_pkg.sv ====
`default_nettype none

package conv_in_pkg;

  // ******************************
  // Sizes
  // ******************************
  localparam int UNITS            = 2;
  localparam int WORD_WIDTH       = 8;
  localparam int KERNEL_H_MAX     = 3;  // odd
  localparam int KERNEL_W_MAX     = 3;
  localparam int CORES            = 4;
  localparam int UNITS_EDGES      = UNITS + KERNEL_H_MAX - 1;
  localparam int WEIGHTS_DMA_BITS = 32;
  localparam int BITS_KERNEL_H    = $clog2(KERNEL_H_MAX);
  localparam int BITS_KERNEL_W    = $clog2(KERNEL_W_MAX);
  localparam int BITS_REPEAT      = 8;
  localparam int BITS_CFG_PAD     = WEIGHTS_DMA_BITS - BITS_REPEAT - BITS_KERNEL_W - 2;

  // Weight rotator FSM
  localparam logic [1:0] ST_HDR    = 2'd0;
  localparam logic [1:0] ST_FILL   = 2'd1;
  localparam logic [1:0] ST_REPLAY = 2'd2;
  localparam logic [1:0] ST_DROP   = 2'd3;  // swallow rest of an over-long packet

  // ******************************
  // Image side
  // ******************************
  typedef struct packed {
    logic                     is_max;
    logic                     is_lrelu;
    logic [BITS_KERNEL_H-1:0] kernel_h_1;
  } image_user_t;

  typedef struct packed {
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] ch1;
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] ch2;
  } pixel_pair_t;

  typedef struct packed {
    logic [UNITS-1:0][WORD_WIDTH-1:0] ch1;
    logic [UNITS-1:0][WORD_WIDTH-1:0] ch2;
  } window_t;

  // ******************************
  // Weight side
  // ******************************
  typedef struct packed {
    logic [BITS_CFG_PAD-1:0]  pad;
    logic [BITS_REPEAT-1:0]   repeat_1;
    logic                     is_acc_last;
    logic                     is_1x1;
    logic [BITS_KERNEL_W-1:0] kernel_w_1;  // LSBs of the header word
  } weight_cfg_t;

  // Header beat vs data beat of the weight DMA stream
  typedef union packed {
    weight_cfg_t                      cfg;
    logic [CORES-1:0][WORD_WIDTH-1:0] bytes;
  } weight_beat_u;

  typedef logic [KERNEL_W_MAX-1:0][CORES-1:0][WORD_WIDTH-1:0] weight_vec_t;

  typedef struct packed {
    logic                     is_1x1;
    logic                     is_acc_last;
    logic [BITS_KERNEL_W-1:0] kernel_w_1;
  } weight_user_t;

  typedef struct packed {
    logic                     is_max;
    logic                     is_lrelu;
    logic                     is_1x1;
    logic                     is_acc_last;
    logic [BITS_KERNEL_W-1:0] kernel_w_1;
  } conv_user_t;

endpackage

`default_nettype wire

// ==== hw/image_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_mux (
  input  wire                                                       aclk,
  input  wire                                                       rst_n,
  input  wire [conv_in_pkg::UNITS_EDGES-1:0][conv_in_pkg::WORD_WIDTH-1:0] px1_data,
  input  wire [conv_in_pkg::UNITS_EDGES-1:0][conv_in_pkg::WORD_WIDTH-1:0] px2_data,
  input  wire conv_in_pkg::image_user_t                             px1_user,
  input  wire                                                       px1_valid,
  input  wire                                                       px2_valid,
  input  wire                                                       out_ready,
  output logic                                                      px1_ready,
  output logic                                                      px2_ready,
  output conv_in_pkg::pixel_pair_t                                  out_data,
  output conv_in_pkg::image_user_t                                  out_user,
  output logic                                                      out_valid
);

  import conv_in_pkg::*;

  logic slot_free;
  logic take;

  // ******************************
  // Lockstep join
  // ******************************

  // Register can take a beat if empty or emptied this cycle
  assign slot_free = !out_valid || out_ready;

  // Each side waits for the other so both transfer on the same edge
  assign px1_ready = px2_valid && slot_free;
  assign px2_ready = px1_valid && slot_free;

  assign take = px1_valid && px2_valid && slot_free;

  // ******************************
  // Output register
  // ******************************

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // Drained, nothing new
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      out_data.ch1 <= px1_data;
      out_data.ch2 <= px2_data;
      out_user     <= px1_user;  // Side-band only rides on stream 1
    end
  end

endmodule

`default_nettype wire

// ==== hw/image_shift_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_shift_buffer (
  input  wire                            aclk,
  input  wire                            rst_n,
  input  wire conv_in_pkg::pixel_pair_t  in_data,
  input  wire conv_in_pkg::image_user_t  in_user,
  input  wire                            in_valid,
  input  wire                            out_ready,
  output logic                           in_ready,
  output conv_in_pkg::window_t           out_data,
  output conv_in_pkg::image_user_t       out_user,
  output logic                           out_valid
);

  import conv_in_pkg::*;

  pixel_pair_t              pair_q;
  logic [BITS_KERNEL_H-1:0] row;
  logic                     last_row;
  logic                     load;

  // ******************************
  // Row sequencing
  // ******************************

  assign last_row = (row == out_user.kernel_h_1);

  // Free again on the edge where the last row leaves, so pairs follow
  // back to back
  assign in_ready = !out_valid || (out_ready && last_row);
  assign load     = in_valid && in_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      row       <= '0;
    end else if (load) begin
      out_valid <= 1'b1;
      row       <= '0;
    end else if (out_valid && out_ready) begin
      if (last_row) begin
        out_valid <= 1'b0;
      end else begin
        row <= row + 1'b1;
      end
    end
  end

  // Stored pair and its side-band
  always_ff @(posedge aclk) begin
    if (load) begin
      pair_q   <= in_data;
      out_user <= in_user;
    end
  end

  // ******************************
  // Window select
  // ******************************

  // Row r takes words r .. r+UNITS-1 of both channels
  always_comb begin
    for (int i = 0; i < UNITS; i++) begin
      out_data.ch1[i] = pair_q.ch1[int'(row) + i];
      out_data.ch2[i] = pair_q.ch2[int'(row) + i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/weight_rotator.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_rotator (
  input  wire                             aclk,
  input  wire                             rst_n,
  input  wire conv_in_pkg::weight_beat_u  in_beat,
  input  wire                             in_last,
  input  wire                             in_valid,
  input  wire                             out_ready,
  output logic                            in_ready,
  output conv_in_pkg::weight_vec_t        out_data,
  output conv_in_pkg::weight_user_t       out_user,
  output logic                            out_last,
  output logic                            out_valid
);

  import conv_in_pkg::*;

  logic [1:0]               state;
  logic [1:0]               state_next;
  logic [BITS_KERNEL_W-1:0] col;
  logic [BITS_REPEAT-1:0]   rep;
  logic                     take;
  logic                     last_col;

  assign take     = in_valid && in_ready;
  assign last_col = (col == out_user.kernel_w_1);

  assign out_valid = (state == ST_REPLAY);
  assign out_last  = (rep == '0);  // Final repeat of the stored set

  // ******************************
  // FSM
  // ******************************

  always_comb begin
    state_next = state;
    case (state)
      ST_HDR: begin
        if (take && !in_last) begin
          state_next = ST_FILL;  // Header alone with tlast is dropped
        end
      end
      ST_FILL: begin
        if (take) begin
          if (in_last && last_col) begin
            state_next = ST_REPLAY;
          end else if (in_last) begin
            state_next = ST_HDR;   // Short packet
          end else if (last_col) begin
            state_next = ST_DROP;  // Long packet, flush to tlast
          end
        end
      end
      ST_DROP: begin
        if (take && in_last) begin
          state_next = ST_HDR;
        end
      end
      default: begin
        if (out_ready && out_last) begin
          state_next = ST_HDR;
        end
      end
    endcase
  end

  // Ready is registered and follows the next state
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state    <= ST_HDR;
      in_ready <= 1'b0;
    end else begin
      state    <= state_next;
      in_ready <= (state_next != ST_REPLAY);
    end
  end

  // ******************************
  // Counters
  // ******************************

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      col <= '0;
      rep <= '0;
    end else if (take && state == ST_HDR) begin
      col <= '0;
      rep <= in_beat.cfg.repeat_1;
    end else if (take && state == ST_FILL) begin
      col <= col + 1'b1;
    end else if (out_valid && out_ready) begin
      rep <= rep - 1'b1;
    end
  end

  // ******************************
  // Weight bank
  // ******************************

  always_ff @(posedge aclk) begin
    if (take && state == ST_HDR) begin
      out_data             <= '0;  // Unused columns stay zero
      out_user.is_1x1      <= in_beat.cfg.is_1x1;
      out_user.is_acc_last <= in_beat.cfg.is_acc_last;
      out_user.kernel_w_1  <= in_beat.cfg.kernel_w_1;
    end else if (take && state == ST_FILL) begin
      out_data[col] <= in_beat.bytes;  // Byte c to core c
    end
  end

endmodule

`default_nettype wire

// ==== hw/axis_input_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_input_pipe (
  input  wire                                                       aclk,
  input  wire                                                       rst_n,
  input  wire [conv_in_pkg::UNITS_EDGES-1:0][conv_in_pkg::WORD_WIDTH-1:0] s_pixels_1_data,
  input  wire [conv_in_pkg::UNITS_EDGES-1:0][conv_in_pkg::WORD_WIDTH-1:0] s_pixels_2_data,
  input  wire conv_in_pkg::image_user_t                             s_pixels_1_user,
  input  wire                                                       s_pixels_1_valid,
  input  wire                                                       s_pixels_2_valid,
  input  wire conv_in_pkg::weight_beat_u                            s_weights_data,
  input  wire                                                       s_weights_last,
  input  wire                                                       s_weights_valid,
  input  wire                                                       m_ready,
  output logic                                                      s_pixels_1_ready,
  output logic                                                      s_pixels_2_ready,
  output logic                                                      s_weights_ready,
  output conv_in_pkg::window_t                                      m_pixels,
  output conv_in_pkg::weight_vec_t                                  m_weights,
  output conv_in_pkg::conv_user_t                                   m_user,
  output logic                                                      m_last,
  output logic                                                      m_valid
);

  import conv_in_pkg::*;

  pixel_pair_t  mux_data;
  image_user_t  mux_user;
  logic         mux_valid;
  logic         mux_ready;
  image_user_t  win_user;
  logic         win_valid;
  logic         win_ready;
  weight_user_t wt_user;
  logic         wt_last;
  logic         wt_valid;
  logic         wt_ready;

  image_mux im_mux (
    .aclk      (aclk), .rst_n     (rst_n),
    .px1_data  (s_pixels_1_data),  .px2_data  (s_pixels_2_data),
    .px1_user  (s_pixels_1_user),
    .px1_valid (s_pixels_1_valid), .px2_valid (s_pixels_2_valid),
    .out_ready (mux_ready),
    .px1_ready (s_pixels_1_ready), .px2_ready (s_pixels_2_ready),
    .out_data  (mux_data), .out_user  (mux_user), .out_valid (mux_valid)
  );

  image_shift_buffer im_shift (
    .aclk      (aclk),      .rst_n     (rst_n),
    .in_data   (mux_data),  .in_user   (mux_user), .in_valid  (mux_valid),
    .out_ready (win_ready), .in_ready  (mux_ready),
    .out_data  (m_pixels),  .out_user  (win_user), .out_valid (win_valid)
  );

  weight_rotator weights_rot (
    .aclk      (aclk),           .rst_n     (rst_n),
    .in_beat   (s_weights_data), .in_last   (s_weights_last),
    .in_valid  (s_weights_valid), .out_ready (wt_ready),
    .in_ready  (s_weights_ready), .out_data  (m_weights),
    .out_user  (wt_user), .out_last  (wt_last), .out_valid (wt_valid)
  );

  // ******************************
  // Stream join
  // ******************************
  assign m_valid   = win_valid && wt_valid;
  assign win_ready = m_ready && wt_valid;
  assign wt_ready  = m_ready && win_valid;

  // Side-band merge
  assign m_last             = wt_last;
  assign m_user.is_max      = win_user.is_max;
  assign m_user.is_lrelu    = win_user.is_lrelu;
  assign m_user.is_1x1      = wt_user.is_1x1;
  assign m_user.is_acc_last = wt_user.is_acc_last;
  assign m_user.kernel_w_1  = wt_user.kernel_w_1;

endmodule

`default_nettype wire

// ==== verification/axis_input_pipe_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_input_pipe_properties (
  input wire                           aclk,
  input wire                           rst_n,
  input wire                           m_valid,
  input wire                           m_ready,
  input wire conv_in_pkg::window_t     m_pixels,
  input wire conv_in_pkg::weight_vec_t m_weights,
  input wire conv_in_pkg::conv_user_t  m_user,
  input wire                           m_last,
  input wire                           s_pixels_1_ready,
  input wire                           s_pixels_2_ready,
  input wire                           s_weights_ready
);

  // ******************************
  // Reset
  // ******************************
  valid_low_after_reset: assert property (@(posedge aclk) !rst_n |=> !m_valid)
    else $error("m_valid high on the cycle after reset");

  pixel_ready_low_in_reset: assert property (
    @(posedge aclk) !rst_n |-> !s_pixels_1_ready && !s_pixels_2_ready)
    else $error("pixel tready high during reset");

  // Weight ready is a register, so it clears one edge into reset
  weight_ready_low_in_reset: assert property (@(posedge aclk) !rst_n |=> !s_weights_ready)
    else $error("weight tready high during reset");

  // ******************************
  // Output hold
  // ******************************
  output_held: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_pixels) && $stable(m_weights)
      && $stable(m_user) && $stable(m_last))
    else $error("m_axis beat changed while stalled");

endmodule

bind axis_input_pipe axis_input_pipe_properties props0 (.*);

`default_nettype wire

// ==== verification/axis_input_pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_input_pipe_tb;

  import conv_in_pkg::*;

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] px_words_t;

  typedef struct packed {
    px_words_t   data;
    image_user_t user;
  } px1_beat_t;

  typedef struct packed {
    weight_beat_u data;
    logic         last;
  } weight_in_t;

  typedef struct packed {
    window_t     win;
    weight_vec_t wts;
    conv_user_t  user;
    logic        last;
  } expected_t;

  logic         aclk;
  logic         rst_n;
  px_words_t    s_pixels_1_data;
  px_words_t    s_pixels_2_data;
  image_user_t  s_pixels_1_user;
  logic         s_pixels_1_valid;
  logic         s_pixels_2_valid;
  logic         s_pixels_1_ready;
  logic         s_pixels_2_ready;
  weight_beat_u s_weights_data;
  logic         s_weights_last;
  logic         s_weights_valid;
  logic         s_weights_ready;
  logic         m_ready;
  window_t      m_pixels;
  weight_vec_t  m_weights;
  conv_user_t   m_user;
  logic         m_last;
  logic         m_valid;

  px1_beat_t  px1_q[$];
  px_words_t  px2_q[$];
  weight_in_t wt_q[$];
  expected_t  exp_q[$];
  int         value_errors;
  int         other_errors;

  axis_input_pipe dut0 (.*);

  always #50 aclk = ~aclk;

  // ******************************
  // Stimulus file
  // ******************************
  task automatic load_stim();
    int          fd;
    int          ch;
    int          n;
    int          fields;
    logic [31:0] word_a;
    logic [31:0] word_b;
    logic [95:0] wide;
    logic [5:0]  user;
    logic        last;
    px1_beat_t   px1;
    weight_in_t  wt;
    expected_t   want;
    fd = $fopen("verification/input_pipe_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file verification/input_pipe_stim.txt");
      other_errors++;
      return;
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      n      = 0;
      fields = 0;
      case (ch)
        "#": begin
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);  // Comment runs to end of line
          end
        end
        "P": begin
          fields = 3;
          n = $fscanf(fd, "%h %h %h", word_a, word_b, user);
          px1.data = word_a;
          px1.user = user[3:0];
          px1_q.push_back(px1);
          px2_q.push_back(word_b);
        end
        "W": begin
          fields = 2;
          n = $fscanf(fd, "%h %b", word_a, last);
          wt.data = word_a;
          wt.last = last;
          wt_q.push_back(wt);
        end
        "E": begin
          fields = 4;
          n = $fscanf(fd, "%h %h %h %b", word_a, wide, user, last);
          want.win  = word_a;
          want.wts  = wide;
          want.user = user;
          want.last = last;
          exp_q.push_back(want);
        end
        default: ;
      endcase
      if (n != fields) begin
        $display("Malformed stimulus record with tag %c", ch);
        other_errors++;
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // ******************************
  // Drivers
  // ******************************
  task automatic drive_pixels_1();
    px1_beat_t beat;
    int        gap;
    while (px1_q.size() > 0) begin
      beat = px1_q.pop_front();
      gap  = $urandom % 3;
      if (gap != 0) begin
        s_pixels_1_valid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      s_pixels_1_valid <= 1'b1;
      s_pixels_1_data  <= beat.data;
      s_pixels_1_user  <= beat.user;
      @(negedge aclk);
      while (!s_pixels_1_ready) begin
        @(negedge aclk);
      end
      @(posedge aclk);  // Transfer edge
    end
    s_pixels_1_valid <= 1'b0;
  endtask

  task automatic drive_pixels_2();
    px_words_t words;
    int        gap;
    while (px2_q.size() > 0) begin
      words = px2_q.pop_front();
      gap   = $urandom % 3;
      if (gap != 0) begin
        s_pixels_2_valid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      s_pixels_2_valid <= 1'b1;
      s_pixels_2_data  <= words;
      @(negedge aclk);
      while (!s_pixels_2_ready) begin
        @(negedge aclk);
      end
      @(posedge aclk);
    end
    s_pixels_2_valid <= 1'b0;
  endtask

  task automatic drive_weights();
    weight_in_t beat;
    int         gap;
    while (wt_q.size() > 0) begin
      beat = wt_q.pop_front();
      gap  = $urandom % 3;
      if (gap != 0) begin
        s_weights_valid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      s_weights_valid <= 1'b1;
      s_weights_data  <= beat.data;
      s_weights_last  <= beat.last;
      @(negedge aclk);
      while (!s_weights_ready) begin
        @(negedge aclk);
      end
      @(posedge aclk);
    end
    s_weights_valid <= 1'b0;
  endtask

  // Random back-pressure on m_axis
  always @(posedge aclk) begin
    m_ready <= ($urandom % 4) != 0;
  end

  // ******************************
  // Checks
  // ******************************
  task automatic compare_window(string name, window_t want, window_t got);
    if (got !== want) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, want, got);
      value_errors++;
    end
  endtask

  task automatic compare_weights(string name, weight_vec_t want, weight_vec_t got);
    if (got !== want) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, want, got);
      value_errors++;
    end
  endtask

  task automatic compare_user(conv_user_t want, conv_user_t got,
                              logic want_last, logic got_last);
    if (got !== want) begin
      $display("error at %0t ns: m_user expected %h, got %h", $time, want, got);
      value_errors++;
    end
    if (got_last !== want_last) begin
      $display("error at %0t ns: m_last expected %b, got %b", $time, want_last, got_last);
      value_errors++;
    end
  endtask

  task automatic check_output();
    expected_t want;
    if (exp_q.size() == 0) begin
      $display("Unexpected output beat at %0t ns with no expected record left", $time);
      other_errors++;
    end else begin
      want = exp_q.pop_front();
      compare_window("m_pixels", want.win, m_pixels);
      compare_weights("m_weights", want.wts, m_weights);
      compare_user(want.user, m_user, want.last, m_last);
    end
  endtask

  // Payload is stable at the falling edge, transfer follows on the next rise
  always @(negedge aclk) begin
    if (rst_n && m_valid && m_ready) begin
      check_output();
    end
  end

  // ******************************
  // Run control
  // ******************************
  task automatic finish_run();
    if (exp_q.size() != 0) begin
      $display("%0d expected output beats never arrived", exp_q.size());
      other_errors++;
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic run_watchdog(int cycles);
    repeat (cycles) @(posedge aclk);
    $display("Timeout after %0d cycles, the run stalled", cycles);
    other_errors++;
    finish_run();
  endtask

  initial begin
    aclk             = 1'b0;
    rst_n            = 1'b0;
    s_pixels_1_data  = '0;
    s_pixels_2_data  = '0;
    s_pixels_1_user  = '0;
    s_pixels_1_valid = 1'b0;
    s_pixels_2_valid = 1'b0;
    s_weights_data   = '0;
    s_weights_last   = 1'b0;
    s_weights_valid  = 1'b0;
    m_ready          = 1'b0;
    value_errors     = 0;
    other_errors     = 0;
    void'($urandom(7715));
    load_stim();
    fork
      run_watchdog(exp_q.size() * 40 + 100);
    join_none
    repeat (2) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    fork
      drive_pixels_1();
      drive_pixels_2();
      drive_weights();
    join_none
    while (exp_q.size() != 0) begin
      @(posedge aclk);
    end
    repeat (20) @(posedge aclk);  // Room for any extra beat to show up
    finish_run();
  end

endmodule

`default_nettype wire

// ==== input_pipe.f ====
hw/conv_in_pkg.sv
hw/image_mux.sv
hw/image_shift_buffer.sv
hw/weight_rotator.sv
hw/axis_input_pipe.sv
verification/axis_input_pipe_properties.sv
verification/axis_input_pipe_tb.sv

// ==== Makefile ====
TOP = axis_input_pipe_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f input_pipe.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== verification/input_pipe_stim.txt ====
# P px1_words px2_words image_user (hex, word 0 in the low byte) | W dma_word last
# E window weight_vec conv_user last (window is ch1 in the high half, then ch2)
P 13121110 23222120 6
P 33323130 43424140 a
P 53525150 63626160 c
P 73727170 83828180 1
W 0000002a 0
W 03020100 0
W 07060504 0
W 0b0a0908 1
W 00000022 0
W 41424344 0
W 51525354 0
W 61626364 1
W 0000000c 0
W a3a2a1a0 1
W 00000002 0
W eeeeeee0 0
W eeeeeee1 1
W 00000019 0
W b3b2b1b0 0
W c3c2c1c0 1
E 11102120 0b0a09080706050403020100 16 0
E 12112221 0b0a09080706050403020100 16 0
E 13122322 0b0a09080706050403020100 16 1
E 31304140 616263645152535441424344 22 0
E 32314241 616263645152535441424344 22 0
E 33324342 616263645152535441424344 22 1
E 51506160 0000000000000000a3a2a1a0 3c 1
E 71708180 00000000c3c2c1c0b3b2b1b0 05 0
E 72718281 00000000c3c2c1c0b3b2b1b0 05 1
